/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= tb_elink_loopback
RTL_TOP    ?= elink_loopback
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Verification failed
RTL_SRCS   ?= src/elink_pkg.sv src/emesh_split.sv src/link_tx.sv src/link_rx.sv \
              src/mem_target.sv src/elink_loopback.sv
LINT_FLAGS ?= --lint-only --timescale 1ns/100ps
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim.f */
src/elink_pkg.sv
src/emesh_split.sv
src/link_tx.sv
src/link_rx.sv
src/mem_target.sv
src/elink_loopback.sv
tb/elink_loopback_props.sv
tb/tb_elink_loopback.sv

/* src/elink_loopback.sv */
`timescale 1ns/100ps

module elink_loopback #(
   parameter int MEM_DEPTH = 64
) (
   input  logic            clk,
   input  logic            rst_n,
   input  elink_pkg::pkt_t req,
   input  logic            req_valid,
   output logic            wr_ready,
   output logic            rd_ready,
   output elink_pkg::pkt_t rsp,
   output logic            rsp_valid,
   input  logic            rsp_ready
);

   elink_pkg::pkt_t       tx_pkt;       // Split to serializer
   logic                  tx_valid;
   logic                  tx_ready;
   logic                  link_frame;   // Looped back link
   elink_pkg::link_byte_t link_data;
   logic                  link_wait;
   elink_pkg::pkt_t       rx_pkt;       // Deserializer to target
   logic                  rx_valid;
   logic                  rx_ready;

   emesh_split split0 (
      .clk(clk), .rst_n(rst_n),
      .req(req), .req_valid(req_valid),
      .wr_ready(wr_ready), .rd_ready(rd_ready),
      .tx_pkt(tx_pkt), .tx_valid(tx_valid), .tx_ready(tx_ready)
   );

   link_tx tx0 (
      .clk(clk), .rst_n(rst_n),
      .tx_pkt(tx_pkt), .tx_valid(tx_valid), .tx_ready(tx_ready),
      .link_frame(link_frame), .link_data(link_data), .link_wait(link_wait)
   );

   link_rx rx0 (
      .clk(clk), .rst_n(rst_n),
      .link_frame(link_frame), .link_data(link_data), .link_wait(link_wait),
      .rx_pkt(rx_pkt), .rx_valid(rx_valid), .rx_ready(rx_ready)
   );

   mem_target #(.MEM_DEPTH(MEM_DEPTH)) mem0 (
      .clk(clk), .rst_n(rst_n),
      .rx_pkt(rx_pkt), .rx_valid(rx_valid), .rx_ready(rx_ready),
      .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
   );

endmodule

/* src/elink_pkg.sv */
package elink_pkg;

   // Field widths of a mesh transaction
   typedef logic [31:0] addr_t;                    // Byte address
   typedef logic [31:0] data_t;                    // Data word
   typedef logic [1:0]  datamode_t;                // Transfer size code
   typedef logic [3:0]  ctrlmode_t;                // Control code

   typedef logic [7:0]  link_byte_t;               // One byte on the link

   // Transaction as it travels on the mesh side
   typedef struct packed {
      logic      write;                            // 1 = write, 0 = read
      datamode_t datamode;                         // Carried through unmasked
      ctrlmode_t ctrlmode;                         // Carried through
      addr_t     dstaddr;                          // Target address
      data_t     data;                             // Write data or read data
      addr_t     srcaddr;                          // Return address for reads
   } pkt_t;

   // Link framing
   localparam int PKT_BYTES = 13;                  // Bytes per framed packet
   localparam int LINK_BW   = $bits(link_byte_t);  // Bits per link beat
   localparam int PKT_BITS  = PKT_BYTES * LINK_BW; // Packet bits incl. pad
   localparam int PAD_BITS  = PKT_BITS - $bits(pkt_t); // Pad at top of first byte
   localparam int CNT_W     = $clog2(PKT_BYTES);   // Byte counter width

   // Memory word indexing
   localparam int WORD_LSB  = 2;                   // Lowest dstaddr bit of word index

   // Serializer FSM
   typedef enum logic {
      IDLE,                                        // Waiting for a packet
      SEND                                         // Shifting bytes out
   } tx_state_t;

endpackage

/* src/emesh_split.sv */
`timescale 1ns/100ps

module emesh_split (
   input  logic            clk,
   input  logic            rst_n,
   input  elink_pkg::pkt_t req,         // Incoming transaction
   input  logic            req_valid,
   output logic            wr_ready,    // Write slot empty
   output logic            rd_ready,    // Read slot empty
   output elink_pkg::pkt_t tx_pkt,      // Toward serializer
   output logic            tx_valid,
   input  logic            tx_ready
);

   elink_pkg::pkt_t wr_slot;            // Pending write
   elink_pkg::pkt_t rd_slot;            // Pending read
   logic            wr_full;
   logic            rd_full;
   logic            grant_rd;           // Round-robin pointer, 1 = read slot
   logic            wr_take;
   logic            rd_take;
   logic            sel_rd;             // Read slot presented to link
   logic            xfer;

   assign wr_ready = ~wr_full;
   assign rd_ready = ~rd_full;

   assign wr_take  = req_valid & req.write & ~wr_full;   // Steer by kind
   assign rd_take  = req_valid & ~req.write & ~rd_full;

   // A lone full slot wins outright, both full follow the pointer
   assign sel_rd   = rd_full & (~wr_full | grant_rd);
   assign tx_valid = wr_full | rd_full;
   assign tx_pkt   = sel_rd ? rd_slot : wr_slot;
   assign xfer     = tx_valid & tx_ready;

   always_ff @(posedge clk) begin
      if (wr_take) begin
         wr_slot <= req;                                  // Capture write
      end
      if (rd_take) begin
         rd_slot <= req;                                  // Capture read
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_full  <= 1'b0;
         rd_full  <= 1'b0;
         grant_rd <= 1'b0;                                // Write first
      end else begin
         if (wr_take) begin
            wr_full <= 1'b1;
         end else if (xfer && !sel_rd) begin
            wr_full <= 1'b0;                              // Write sent
         end
         if (rd_take) begin
            rd_full <= 1'b1;
         end else if (xfer && sel_rd) begin
            rd_full <= 1'b0;                              // Read sent
         end
         // Pointer tracks the presented slot so the link sees a stable packet
         if (xfer && wr_full && rd_full) begin
            grant_rd <= ~grant_rd;                        // Hand over to other slot
         end else if (wr_full ^ rd_full) begin
            grant_rd <= rd_full;                          // Follow lone slot
         end
      end
   end

endmodule

/* src/link_rx.sv */
`timescale 1ns/100ps

module link_rx (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  link_frame,
   input  elink_pkg::link_byte_t link_data,
   output logic                  link_wait,  // Held while packet unclaimed
   output elink_pkg::pkt_t       rx_pkt,
   output logic                  rx_valid,
   input  logic                  rx_ready
);

   localparam int PW = $bits(elink_pkg::pkt_t);
   localparam logic [elink_pkg::CNT_W-1:0] LAST =
      elink_pkg::CNT_W'(elink_pkg::PKT_BYTES - 1);

   logic [PW-1:0]               shreg;   // Pad bit drops off the top
   logic [elink_pkg::CNT_W-1:0] cnt;     // Bytes of current packet

   assign rx_pkt    = elink_pkg::pkt_t'(shreg);
   assign link_wait = rx_valid;

   always_ff @(posedge clk) begin
      if (link_frame) begin
         shreg <= {shreg[PW-elink_pkg::LINK_BW-1:0], link_data};  // MSB byte first
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt      <= '0;
         rx_valid <= 1'b0;
      end else begin
         if (link_frame) begin
            if (cnt == LAST) begin
               cnt      <= '0;
               rx_valid <= 1'b1;          // Whole packet in
            end else begin
               cnt <= cnt + 1'b1;
            end
         end else if (rx_valid && rx_ready) begin
            rx_valid <= 1'b0;             // Target took it, release wait
         end
      end
   end

endmodule

/* src/link_tx.sv */
`timescale 1ns/100ps

module link_tx (
   input  logic                  clk,
   input  logic                  rst_n,
   input  elink_pkg::pkt_t       tx_pkt,
   input  logic                  tx_valid,
   output logic                  tx_ready,   // Idle and link not held
   output logic                  link_frame, // High for every packet byte
   output elink_pkg::link_byte_t link_data,
   input  logic                  link_wait   // Receiver still holds a packet
);

   localparam logic [elink_pkg::CNT_W-1:0] LAST =
      elink_pkg::CNT_W'(elink_pkg::PKT_BYTES - 1);  // Index of final byte

   elink_pkg::tx_state_t              state;
   logic [elink_pkg::PKT_BITS-1:0]    shreg;        // Outgoing bytes, MSB first
   logic [elink_pkg::CNT_W-1:0]       cnt;          // Bytes already sent
   logic                              accept;

   // Wait is only sampled before a packet starts
   assign tx_ready   = (state == elink_pkg::IDLE) & ~link_wait;
   assign accept     = tx_valid & tx_ready;
   assign link_frame = (state == elink_pkg::SEND);
   assign link_data  = shreg[elink_pkg::PKT_BITS-1 -: elink_pkg::LINK_BW];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= elink_pkg::IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            elink_pkg::IDLE: begin
               if (accept) begin
                  state <= elink_pkg::SEND;          // Frame rises next cycle
                  cnt   <= '0;
               end
            end
            elink_pkg::SEND: begin
               cnt <= cnt + 1'b1;
               if (cnt == LAST) begin
                  state <= elink_pkg::IDLE;          // Last byte on the wire
               end
            end
            default: state <= elink_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         shreg <= {{elink_pkg::PAD_BITS{1'b0}}, tx_pkt};   // Pad bit on top
      end else if (state == elink_pkg::SEND) begin
         shreg <= {shreg[elink_pkg::PKT_BITS-elink_pkg::LINK_BW-1:0],
                   elink_pkg::link_byte_t'(0)};            // Next byte up
      end
   end

endmodule

/* src/mem_target.sv */
`timescale 1ns/100ps

module mem_target #(
   parameter int MEM_DEPTH = 64          // Words, power of two
) (
   input  logic            clk,
   input  logic            rst_n,
   input  elink_pkg::pkt_t rx_pkt,
   input  logic            rx_valid,
   output logic            rx_ready,     // Response slot free
   output elink_pkg::pkt_t rsp,          // Read response
   output logic            rsp_valid,
   input  logic            rsp_ready
);

   localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

   elink_pkg::data_t  mem [MEM_DEPTH];   // Word storage
   logic [IDX_W-1:0]  idx;
   logic              rx_fire;

   assign idx      = rx_pkt.dstaddr[elink_pkg::WORD_LSB +: IDX_W];  // Word select
   assign rx_ready = ~rsp_valid;         // Writes stall too while slot full
   assign rx_fire  = rx_valid & rx_ready;

   always_ff @(posedge clk) begin
      if (rx_fire && rx_pkt.write) begin
         mem[idx] <= rx_pkt.data;        // Full word, datamode ignored
      end
   end

   // Response payload, swaps the two addresses
   always_ff @(posedge clk) begin
      if (rx_fire && !rx_pkt.write) begin
         rsp.write    <= 1'b1;           // Returns as a write
         rsp.datamode <= rx_pkt.datamode;
         rsp.ctrlmode <= rx_pkt.ctrlmode;
         rsp.dstaddr  <= rx_pkt.srcaddr; // Back to requester
         rsp.data     <= mem[idx];
         rsp.srcaddr  <= rx_pkt.dstaddr;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (rx_fire && !rx_pkt.write) begin
         rsp_valid <= 1'b1;              // Visible next cycle
      end else if (rsp_valid && rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

endmodule

/* tb/elink_loopback_props.sv */
`timescale 1ns/100ps

module elink_loopback_props (
   input logic            clk,
   input logic            rst_n,
   input elink_pkg::pkt_t tx_pkt,
   input logic            tx_valid,
   input logic            tx_ready,
   input logic            link_frame,
   input logic            link_wait,
   input elink_pkg::pkt_t rsp,
   input logic            rsp_valid,
   input logic            rsp_ready
);

   logic [elink_pkg::CNT_W:0] run;   // Consecutive frame cycles so far
   int fail_tx = 0;
   int fail_rsp = 0;
   int fail_run = 0;
   int fail_gap = 0;
   int fail_wait = 0;
   int assert_fails;

   assign assert_fails = fail_tx + fail_rsp + fail_run + fail_gap + fail_wait;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run <= '0;
      end else begin
         run <= link_frame ? run + 1'b1 : '0;
      end
   end

   tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_pkt))
      else begin $error("tx packet dropped or changed while stalled"); fail_tx++; end

   rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
      else begin $error("response dropped or changed while stalled"); fail_rsp++; end

   frame_max: assert property (@(posedge clk) disable iff (!rst_n)
      link_frame |-> run < elink_pkg::PKT_BYTES)
      else begin $error("frame longer than one packet"); fail_run++; end

   frame_len: assert property (@(posedge clk) disable iff (!rst_n)
      !link_frame && run != 0 |-> run == elink_pkg::PKT_BYTES)
      else begin $error("frame shorter than one packet"); fail_gap++; end

   wait_low: assert property (@(posedge clk) $rose(rst_n) |-> !link_wait)
      else begin $error("link wait high out of reset"); fail_wait++; end

endmodule

bind elink_loopback elink_loopback_props props0 (
   .clk(clk), .rst_n(rst_n), .tx_pkt(tx_pkt), .tx_valid(tx_valid),
   .tx_ready(tx_ready), .link_frame(link_frame), .link_wait(link_wait),
   .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
);

/* tb/tb_elink_loopback.sv */
`timescale 1ns/100ps

module tb_elink_loopback;

   localparam int MEM_DEPTH = 64;
   localparam int HALF_PER  = 20;                   // 40 ns clock
   localparam int IN_DLY    = 2;                    // Drive after rising edge
   localparam int DRAIN     = 2 * 14 + 4;           // Settle bound of one transaction
   localparam int N_TXN     = 32 + 8 + 24 + 12 + 3; // All requests of all tests
   localparam int WDOG_CYC  = N_TXN * 32 + 500;

   logic            clk = 1'b0;
   logic            rst_n;
   elink_pkg::pkt_t req;
   logic            req_valid;
   logic            wr_ready;
   logic            rd_ready;
   elink_pkg::pkt_t rsp;
   logic            rsp_valid;
   logic            rsp_ready;

   integer           seed = 32'h6bc7;
   int               errors = 0;
   int               checks = 0;
   int               n_rsp = 0;                     // Responses seen
   int               n_rd = 0;                      // Reads accepted
   elink_pkg::data_t shadow [MEM_DEPTH];            // Reference memory
   elink_pkg::pkt_t  exp_q [$];                     // Expected responses in read issue order
   int unsigned      a_idx [16];                    // Words written in test 2

   elink_loopback #(.MEM_DEPTH(MEM_DEPTH)) dut0 (
      .clk(clk), .rst_n(rst_n), .req(req), .req_valid(req_valid),
      .wr_ready(wr_ready), .rd_ready(rd_ready),
      .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
   );

   always #HALF_PER clk = ~clk;

   function automatic int unsigned word_of(elink_pkg::addr_t a);
      return (a >> elink_pkg::WORD_LSB) % MEM_DEPTH;        // Bits above byte offset
   endfunction

   function automatic elink_pkg::addr_t addr_of(int unsigned w, elink_pkg::addr_t noise);
      elink_pkg::addr_t mask;
      mask = elink_pkg::addr_t'(MEM_DEPTH - 1) << elink_pkg::WORD_LSB;
      return (noise & ~mask) | (elink_pkg::addr_t'(w) << elink_pkg::WORD_LSB);
   endfunction

   // Target answers as a write with swapped addresses and kept modes
   function automatic elink_pkg::pkt_t expected_rsp(elink_pkg::pkt_t r, elink_pkg::data_t word);
      elink_pkg::pkt_t p;
      p         = r;
      p.write   = 1'b1;
      p.dstaddr = r.srcaddr;
      p.srcaddr = r.dstaddr;
      p.data    = word;
      return p;
   endfunction

   function automatic elink_pkg::pkt_t rand_pkt(logic wr, int unsigned w);
      elink_pkg::pkt_t p;
      p.write    = wr;
      p.datamode = elink_pkg::datamode_t'($random(seed));
      p.ctrlmode = elink_pkg::ctrlmode_t'($random(seed));
      p.dstaddr  = addr_of(w, $random(seed));      // Noise above the index
      p.data     = $random(seed);
      p.srcaddr  = $random(seed);
      return p;
   endfunction

   task automatic check_pkt(input string name, input elink_pkg::pkt_t got,
                            input elink_pkg::pkt_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0d ns: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_data(input string name, input elink_pkg::data_t got,
                             input elink_pkg::data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0d ns: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0d ns: %s got %b, expected %b", $time, name, got, exp);
      end
   endtask

   // Starts just after a rising edge and returns just after the accepting edge
   task automatic send(input elink_pkg::pkt_t p);
      logic done;
      req       = p;
      req_valid = 1'b1;
      done      = 1'b0;
      while (!done) begin
         @(negedge clk);
         done = p.write ? wr_ready : rd_ready;     // Ready of its kind
         @(posedge clk);
      end
      if (p.write) begin
         shadow[word_of(p.dstaddr)] = p.data;
      end else begin
         exp_q.push_back(expected_rsp(p, shadow[word_of(p.dstaddr)]));
         n_rd++;
      end
      #IN_DLY;
      req_valid = 1'b0;
   endtask

   task automatic settle();
      repeat (DRAIN) @(posedge clk);
      #IN_DLY;
   endtask

   task automatic wait_rsp();
      while (exp_q.size() != 0) @(posedge clk);     // Until every read is answered
      repeat (2) @(posedge clk);
      #IN_DLY;
   endtask

   task automatic report(input string name, input int e0);
      $display("Test %s: %0d errors", name, errors - e0);
   endtask

   // Handshake completes on the next rising edge
   always @(negedge clk) begin
      if (rst_n && rsp_valid && rsp_ready) begin
         n_rsp++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0d ns: response arrived with no read outstanding", $time);
         end else begin
            check_data("rsp.data", rsp.data, exp_q[0].data);
            check_pkt("rsp", rsp, exp_q.pop_front());
         end
      end
   end

   initial begin
      repeat (WDOG_CYC) @(posedge clk);
      $display("Timeout: run still busy after %0d cycles", WDOG_CYC);
      $display("Verification failed");
      $finish;
   end

   initial begin
      elink_pkg::pkt_t p;
      int unsigned     w;
      int              e0;
      logic            both_low;
      req       = '0;
      req_valid = 1'b0;
      rsp_ready = 1'b1;
      rst_n     = 1'b0;
      repeat (16) @(posedge clk);
      #IN_DLY rst_n = 1'b1;

      e0 = errors;                                  // Idle state after reset
      @(negedge clk);
      check_flag("wr_ready", wr_ready, 1'b1);
      check_flag("rd_ready", rd_ready, 1'b1);
      check_flag("rsp_valid", rsp_valid, 1'b0);
      @(posedge clk);
      #IN_DLY;
      report("1 reset", e0);

      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         a_idx[i] = 2 * i + ($random(seed) & 1);  // Distinct words in the lower half
         send(rand_pkt(1'b1, a_idx[i]));
      end
      settle();
      for (int i = 0; i < 16; i++) send(rand_pkt(1'b0, a_idx[i]));
      wait_rsp();
      report("2 write then read", e0);

      e0 = errors;
      for (int i = 0; i < 8; i++) begin
         p          = rand_pkt(1'b0, a_idx[2 * i]);
         p.datamode = elink_pkg::datamode_t'(i);
         p.ctrlmode = elink_pkg::ctrlmode_t'(15 - 2 * i);
         send(p);
      end
      wait_rsp();
      report("3 modes returned", e0);

      e0 = errors;
      for (int i = 0; i < 24; i++) begin
         w = $unsigned($random(seed));
         if (w[0]) send(rand_pkt(1'b0, a_idx[w[8:1] % 16]));
         else      send(rand_pkt(1'b1, MEM_DEPTH / 2 + w[8:1] % (MEM_DEPTH / 2)));
      end
      wait_rsp();
      settle();
      report("4 mixed stream", e0);

      e0        = errors;
      rsp_ready = 1'b0;
      both_low  = 1'b0;
      fork
         for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0) send(rand_pkt(1'b0, a_idx[i]));
            else            send(rand_pkt(1'b1, MEM_DEPTH / 2 + i));
         end
         begin
            repeat (60) begin
               @(negedge clk);
               if (!wr_ready && !rd_ready) both_low = 1'b1;
            end
            @(posedge clk);
            #IN_DLY rsp_ready = 1'b1;               // Release the stall
         end
      join
      check_flag("wr_ready and rd_ready both low", both_low, 1'b1);
      wait_rsp();
      settle();
      if (n_rsp != n_rd) begin
         errors++;
         $display("Error: %0d responses returned for %0d reads", n_rsp, n_rd);
      end
      report("5 back-pressure", e0);

      e0 = errors;
      w  = a_idx[5];
      send(rand_pkt(1'b1, w));
      send(rand_pkt(1'b1, w));                      // Newer data wins
      settle();
      send(rand_pkt(1'b0, w));
      wait_rsp();
      report("6 rewrite", e0);

      errors = errors + dut0.props0.assert_fails;
      $display("Done: %0d checks, %0d responses, %0d assertion failures, %0d errors",
               checks, n_rsp, dut0.props0.assert_fails, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
